//--- design/tilemap_pkg.sv
package tilemap_pkg;

	//////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////

	typedef logic [2:0] pri_t;
	typedef logic [7:0] color_t;
	typedef logic [2:0] dot_t;

	// One bit per pixel of a four-pixel group
	typedef logic [3:0] plane_t;

	// Plane 0 sits in the low nibble
	typedef plane_t [2:0] gfx_t;

	//////////////////////////////////////////////////
	// Chain pixel and tile fetch
	//////////////////////////////////////////////////

	typedef struct packed {
		pri_t   pri;
		color_t color;
		dot_t   dot;
	} pixel_t;

	typedef struct packed {
		color_t attr;
		gfx_t   gfx;
	} tile_t;

	typedef enum logic [1:0] {
		LINE_IDLE   = 2'd0,
		LINE_ACTIVE = 2'd1,
		LINE_BLANK  = 2'd2
	} line_state_e;

	// All three planes set means no dot
	localparam dot_t TRANSPARENT_DOT = 3'd7;

	// Bottom of the priority chain
	localparam pixel_t BACKDROP_PIXEL = '{
		pri:   3'd0,
		color: 8'd0,
		dot:   TRANSPARENT_DOT
	};

endpackage

//--- design/pixel_phase_timer.sv
`timescale 1ns/1ps

module pixel_phase_timer import tilemap_pkg::*; #(
	parameter int ACTIVE_GROUPS = 8,
	parameter int BLANK_GROUPS  = 3
) (
	input  logic       CLK_2H,
	input  logic       rst_n,
	input  logic       running,
	input  logic       seg_active,
	output logic [1:0] phase,
	output logic       fetch_strobe,
	output logic       load_strobe,
	output logic       group_last
);

	localparam int MAX_GROUPS = (ACTIVE_GROUPS > BLANK_GROUPS) ? ACTIVE_GROUPS : BLANK_GROUPS;
	localparam int GROUP_W    = $clog2(MAX_GROUPS) + 1;

	logic [GROUP_W-1:0] group_cnt;
	logic [GROUP_W-1:0] group_end;

	// Index of the final group in the current segment
	assign group_end = seg_active ? GROUP_W'(ACTIVE_GROUPS - 1) : GROUP_W'(BLANK_GROUPS - 1);

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			phase     <= 2'd0;
			group_cnt <= '0;
		end else if (!running) begin
			phase     <= 2'd0;
			group_cnt <= '0;
		end else begin
			phase <= phase + 2'd1;
			if (group_last) begin
				group_cnt <= '0;
			end else if (phase == 2'd3) begin
				group_cnt <= group_cnt + 1'b1;
			end
		end
	end

	// Fetch mid-group, load on the last pixel
	assign fetch_strobe = (phase == 2'd1);
	assign load_strobe  = (phase == 2'd3);
	assign group_last   = (phase == 2'd3) && (group_cnt == group_end);

endmodule

//--- design/line_controller.sv
`timescale 1ns/1ps

module line_controller import tilemap_pkg::*; (
	input  logic CLK_2H,
	input  logic rst_n,
	input  logic enable,
	input  logic group_last,
	input  logic load_strobe,
	output logic running,
	output logic seg_active,
	output logic active
);

	line_state_e state;
	line_state_e state_next;

	//////////////////////////////////////////////////
	// Segment sequencing
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			LINE_IDLE: begin
				if (enable) begin
					state_next = LINE_ACTIVE;
				end
			end
			LINE_ACTIVE: begin
				if (group_last) begin
					state_next = LINE_BLANK;
				end
			end
			LINE_BLANK: begin
				// Finish the line before dropping back to idle
				if (group_last) begin
					state_next = enable ? LINE_ACTIVE : LINE_IDLE;
				end
			end
			default: begin
				state_next = LINE_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			state <= LINE_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign running    = (state != LINE_IDLE);
	assign seg_active = (state == LINE_ACTIVE);

	//////////////////////////////////////////////////
	// Group ownership
	//////////////////////////////////////////////////

	// Segment of the next group to load, settled one group ahead
	// so the layers sample it on their own load edge
	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (load_strobe || (state == LINE_IDLE)) begin
			active <= (state_next == LINE_ACTIVE);
		end
	end

endmodule

//--- design/layer_priority_regs.sv
`timescale 1ns/1ps

module layer_priority_regs import tilemap_pkg::*; #(
	parameter pri_t RESET_PRIORITY0 = 3'd2,
	parameter pri_t RESET_PRIORITY1 = 3'd5
) (
	input  logic CLK_2H,
	input  logic rst_n,
	input  logic pri_wr,
	input  logic pri_layer,
	input  pri_t pri_data,
	output pri_t pri0,
	output pri_t pri1
);

	//////////////////////////////////////////////////
	// CPU priority write
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			pri0 <= RESET_PRIORITY0;
		end else if (pri_wr && !pri_layer) begin
			pri0 <= pri_data;
		end
	end

	// Layer select bit high addresses layer 1
	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			pri1 <= RESET_PRIORITY1;
		end else if (pri_wr && pri_layer) begin
			pri1 <= pri_data;
		end
	end

endmodule

//--- design/tile_layer.sv
`timescale 1ns/1ps

module tile_layer import tilemap_pkg::*; #(
	parameter int LAYER_ID = 0
) (
	input  logic   CLK_2H,
	input  logic   rst_n,
	input  tile_t  tile,
	input  logic   fetch_strobe,
	input  logic   load_strobe,
	input  logic   active,
	input  logic   flip,
	input  pri_t   pri,
	input  pixel_t pix_in,
	output pixel_t pix_out,
	output logic   valid_out
);

	tile_t  hold_q;
	gfx_t   shift_q;
	color_t attr_q;
	logic   grp_active;
	dot_t   front_dot;

	// Own dot wins only if opaque and strictly above
	function automatic logic wins(dot_t dot, pri_t own_pri, pri_t in_pri);
		return (dot != TRANSPARENT_DOT) && (own_pri > in_pri);
	endfunction

	//////////////////////////////////////////////////
	// Fetch hold and plane shifters
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (fetch_strobe) begin
			hold_q <= tile;
		end
	end

	always_ff @(posedge CLK_2H) begin
		if (load_strobe) begin
			shift_q <= hold_q.gfx;
			attr_q  <= hold_q.attr;
		end else begin
			for (int p = 0; p < 3; p++) begin
				shift_q[p] <= flip ? (shift_q[p] >> 1) : (shift_q[p] << 1);
			end
		end
	end

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			grp_active <= 1'b0;
			valid_out  <= 1'b0;
		end else begin
			if (load_strobe) begin
				grp_active <= active;
			end
			valid_out <= grp_active;
		end
	end

	// Front of each plane, plane 2 is the dot MSB
	assign front_dot = flip ? {shift_q[2][0], shift_q[1][0], shift_q[0][0]}
		: {shift_q[2][3], shift_q[1][3], shift_q[0][3]};

	//////////////////////////////////////////////////
	// Priority mix
	//////////////////////////////////////////////////

	generate
		if (LAYER_ID == 0) begin : g_base
			// Bottom layer registers the mix directly
			always_ff @(posedge CLK_2H) begin
				if (!rst_n) begin
					pix_out <= BACKDROP_PIXEL;
				end else if (grp_active && wins(front_dot, pri, pix_in.pri)) begin
					pix_out <= '{pri: pri, color: attr_q, dot: front_dot};
				end else begin
					pix_out <= pix_in;
				end
			end
		end else begin : g_upper
			color_t cand_color;
			dot_t   cand_dot;

			// Stage own pixel to line up with the registered pixel below
			always_ff @(posedge CLK_2H) begin
				cand_color <= attr_q;
				cand_dot   <= front_dot;
			end

			always_comb begin
				if (valid_out && wins(cand_dot, pri, pix_in.pri)) begin
					pix_out = '{pri: pri, color: cand_color, dot: cand_dot};
				end else begin
					pix_out = pix_in;
				end
			end
		end
	endgenerate

endmodule

//--- design/tilemap_mixer_top.sv
`timescale 1ns/1ps

module tilemap_mixer_top import tilemap_pkg::*; #(
	parameter int   ACTIVE_GROUPS   = 8,
	parameter int   BLANK_GROUPS    = 3,
	parameter pri_t RESET_PRIORITY0 = 3'd2,
	parameter pri_t RESET_PRIORITY1 = 3'd5
) (
	input  logic   CLK_2H,
	input  logic   rst_n,
	input  logic   enable,
	input  logic   flip,
	input  tile_t  tile0,
	input  tile_t  tile1,
	input  logic   pri_wr,
	input  logic   pri_layer,
	input  pri_t   pri_data,
	output pixel_t pix,
	output logic   pixel_valid
);

	logic   running;
	logic   seg_active;
	logic   active;
	logic   fetch_strobe;
	logic   load_strobe;
	logic   group_last;
	pri_t   pri0;
	pri_t   pri1;
	pixel_t mid_pix;

	//////////////////////////////////////////////////
	// Line timing
	//////////////////////////////////////////////////

	pixel_phase_timer #(
		.ACTIVE_GROUPS (ACTIVE_GROUPS),
		.BLANK_GROUPS  (BLANK_GROUPS)
	) u_timer (
		.CLK_2H       (CLK_2H),
		.rst_n        (rst_n),
		.running      (running),
		.seg_active   (seg_active),
		.phase        (),
		.fetch_strobe (fetch_strobe),
		.load_strobe  (load_strobe),
		.group_last   (group_last)
	);

	line_controller u_ctrl (
		.CLK_2H      (CLK_2H),
		.rst_n       (rst_n),
		.enable      (enable),
		.group_last  (group_last),
		.load_strobe (load_strobe),
		.running     (running),
		.seg_active  (seg_active),
		.active      (active)
	);

	layer_priority_regs #(
		.RESET_PRIORITY0 (RESET_PRIORITY0),
		.RESET_PRIORITY1 (RESET_PRIORITY1)
	) u_pri (
		.CLK_2H    (CLK_2H),
		.rst_n     (rst_n),
		.pri_wr    (pri_wr),
		.pri_layer (pri_layer),
		.pri_data  (pri_data),
		.pri0      (pri0),
		.pri1      (pri1)
	);

	//////////////////////////////////////////////////
	// Layer chain, backdrop first
	//////////////////////////////////////////////////

	tile_layer #(.LAYER_ID(0)) u_layer0 (
		.CLK_2H       (CLK_2H),
		.rst_n        (rst_n),
		.tile         (tile0),
		.fetch_strobe (fetch_strobe),
		.load_strobe  (load_strobe),
		.active       (active),
		.flip         (flip),
		.pri          (pri0),
		.pix_in       (BACKDROP_PIXEL),
		.pix_out      (mid_pix),
		.valid_out    ()
	);

	tile_layer #(.LAYER_ID(1)) u_layer1 (
		.CLK_2H       (CLK_2H),
		.rst_n        (rst_n),
		.tile         (tile1),
		.fetch_strobe (fetch_strobe),
		.load_strobe  (load_strobe),
		.active       (active),
		.flip         (flip),
		.pri          (pri1),
		.pix_in       (mid_pix),
		.pix_out      (pix),
		.valid_out    (pixel_valid)
	);

endmodule

//--- testbench/tb_tilemap_mixer.sv
`timescale 1ns/1ps

module tb_tilemap_mixer import tilemap_pkg::*; ();

	localparam int          ACTIVE_GROUPS   = 8;
	localparam int          BLANK_GROUPS    = 3;
	localparam pri_t        RESET_PRIORITY0 = 3'd2;
	localparam pri_t        RESET_PRIORITY1 = 3'd5;
	localparam int          LINE_CYCLES     = 4 * (ACTIVE_GROUPS + BLANK_GROUPS);
	localparam int          RUN_PIXELS      = 4 * ACTIVE_GROUPS;
	localparam int          DRAIN_TIMEOUT   = 4 * LINE_CYCLES;
	localparam logic [31:0] SEED            = 32'h352019b1;

	logic   CLK_2H;
	logic   rst_n;
	logic   enable;
	logic   flip;
	tile_t  tile0;
	tile_t  tile1;
	logic   pri_wr;
	logic   pri_layer;
	pri_t   pri_data;
	pixel_t pix;
	logic   pixel_valid;

	// Reference model state
	pri_t   model_pri0;
	pri_t   model_pri1;
	pixel_t exp_q[$];
	tile_t  replay0_q[$];
	tile_t  replay1_q[$];

	// Monitor state
	string test_name;
	logic  mon_on;
	int    run_len;
	int    runs_seen;

	tilemap_mixer_top #(
		.ACTIVE_GROUPS   (ACTIVE_GROUPS),
		.BLANK_GROUPS    (BLANK_GROUPS),
		.RESET_PRIORITY0 (RESET_PRIORITY0),
		.RESET_PRIORITY1 (RESET_PRIORITY1)
	) DUT (
		.CLK_2H      (CLK_2H),
		.rst_n       (rst_n),
		.enable      (enable),
		.flip        (flip),
		.tile0       (tile0),
		.tile1       (tile1),
		.pri_wr      (pri_wr),
		.pri_layer   (pri_layer),
		.pri_data    (pri_data),
		.pix         (pix),
		.pixel_valid (pixel_valid)
	);

	initial begin
		CLK_2H = 1'b0;
		forever begin
			#50 CLK_2H = ~CLK_2H;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic report_failure();
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pixel(string name, pixel_t exp, pixel_t act);
		if (act !== exp) begin
			$display("Fail %s: expected pri %0d color %h dot %0d, actual pri %0d color %h dot %0d",
				name, exp.pri, exp.color, exp.dot, act.pri, act.color, act.dot);
			report_failure();
		end
	endtask

	task automatic check_priority(string name, pri_t exp, pri_t act);
		if (act !== exp) begin
			$display("Fail %s: expected priority %0d, actual priority %0d", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_valid(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("Fail %s: expected pixel_valid %b, actual pixel_valid %b", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			report_failure();
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Dot k of a group in shift-out order
	function automatic dot_t group_dot(tile_t t, int k, logic flipped);
		logic [11:0] g;
		int          b;
		g = t.gfx;
		b = flipped ? k : 3 - k;
		return {g[8 + b], g[4 + b], g[b]};
	endfunction

	function automatic pixel_t mix_layer(pixel_t below, pri_t p, color_t c, dot_t d);
		pixel_t result;
		result = below;
		// Ties keep the lower pixel
		if ((d != TRANSPARENT_DOT) && (p > below.pri)) begin
			result.pri   = p;
			result.color = c;
			result.dot   = d;
		end
		return result;
	endfunction

	task automatic push_group(tile_t t0, tile_t t1, logic flipped);
		pixel_t p;
		for (int k = 0; k < 4; k++) begin
			p = BACKDROP_PIXEL;
			p = mix_layer(p, model_pri0, t0.attr, group_dot(t0, k, flipped));
			p = mix_layer(p, model_pri1, t1.attr, group_dot(t1, k, flipped));
			exp_q.push_back(p);
		end
	endtask

	function automatic tile_t random_tile();
		logic [31:0] r;
		logic [31:0] mask;
		tile_t       t;
		r    = $urandom;
		mask = $urandom;
		t    = r[19:0];
		// Extra set bits now and then so transparent dots show up often
		if (mask[1:0] == 2'd0) begin
			t.gfx = t.gfx | mask[31:20];
		end
		return t;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic write_priority(logic layer, pri_t value);
		@(posedge CLK_2H);
		pri_wr    <= 1'b1;
		pri_layer <= layer;
		pri_data  <= value;
		@(posedge CLK_2H);
		pri_wr <= 1'b0;
		if (layer) begin
			model_pri1 = value;
		end else begin
			model_pri0 = value;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
			@(negedge CLK_2H);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d expected pixels never came out", exp_q.size());
			report_failure();
		end
	endtask

	task automatic quiet_check(string name, int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge CLK_2H);
			check_valid({name, " idle"}, 1'b0, pixel_valid);
		end
	endtask

	// Cycle count from the enable edge gives the timer phase
	task automatic run_lines(string name, int n_lines, logic flip_val, logic replay,
		logic random_pri);
		int          total;
		int          grp;
		tile_t       t0;
		tile_t       t1;
		logic [31:0] r;
		test_name = name;
		runs_seen = 0;
		total     = LINE_CYCLES * n_lines + 16;
		if (!replay) begin
			replay0_q.delete();
			replay1_q.delete();
		end
		@(posedge CLK_2H);
		flip   <= flip_val;
		enable <= 1'b1;
		for (int cyc = 1; cyc <= total; cyc++) begin
			@(posedge CLK_2H);
			pri_wr <= 1'b0;
			// Drop enable early in the last line
			if (cyc == LINE_CYCLES * (n_lines - 1) + 5) begin
				enable <= 1'b0;
			end
			// Tile for the coming fetch strobe
			if ((cyc % 4 == 2) && (cyc < LINE_CYCLES * n_lines)) begin
				if (replay) begin
					t0 = replay0_q.pop_front();
					t1 = replay1_q.pop_front();
				end else begin
					t0 = random_tile();
					t1 = random_tile();
					replay0_q.push_back(t0);
					replay1_q.push_back(t1);
				end
				tile0 <= t0;
				tile1 <= t1;
				grp = ((cyc - 2) % LINE_CYCLES) / 4;
				if (grp < ACTIVE_GROUPS) begin
					push_group(t0, t1, flip_val);
				end
			end
			// Late blanking with no active group shifting
			if (random_pri && (cyc % LINE_CYCLES == LINE_CYCLES - 3)) begin
				r = $urandom;
				if (r[0]) begin
					pri_wr    <= 1'b1;
					pri_layer <= r[1];
					pri_data  <= r[4:2];
					if (r[1]) begin
						model_pri1 = r[4:2];
					end else begin
						model_pri0 = r[4:2];
					end
				end
			end
		end
		wait_drain();
		check_count({name, " runs"}, n_lines, runs_seen);
		quiet_check(name, 2 * LINE_CYCLES);
	endtask

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	always @(negedge CLK_2H) begin : pixel_monitor
		pixel_t exp_pix;
		if (mon_on) begin
			if (pixel_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("pixel_valid went high with no expected pixel in %s", test_name);
					report_failure();
				end else begin
					exp_pix = exp_q.pop_front();
					if (pix.dot != TRANSPARENT_DOT) begin
						check_priority(test_name, exp_pix.pri, pix.pri);
					end
					check_pixel(test_name, exp_pix, pix);
				end
				run_len++;
			end else begin
				// Blanking shows the backdrop
				check_pixel({test_name, " backdrop"}, BACKDROP_PIXEL, pix);
				if (run_len != 0) begin
					check_count({test_name, " run length"}, RUN_PIXELS, run_len);
					runs_seen++;
					run_len = 0;
				end
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		rst_n       = 1'b0;
		enable      = 1'b0;
		flip        = 1'b0;
		tile0       = '0;
		tile1       = '0;
		pri_wr      = 1'b0;
		pri_layer   = 1'b0;
		pri_data    = '0;
		model_pri0  = RESET_PRIORITY0;
		model_pri1  = RESET_PRIORITY1;
		mon_on      = 1'b0;
		run_len     = 0;
		runs_seen   = 0;
		test_name   = "reset";

		for (int i = 0; i < 16; i++) begin
			@(posedge CLK_2H);
			mon_on <= 1'b1;
			if (i == 15) begin
				rst_n <= 1'b1;
			end
			@(negedge CLK_2H);
			check_valid("reset", 1'b0, pixel_valid);
		end
		test_name = "before enable";
		quiet_check("before enable", 8);

		run_lines("normal order", 2, 1'b0, 1'b0, 1'b0);
		run_lines("flip order", 2, 1'b1, 1'b1, 1'b0);

		// Equal priorities keep layer 0 on top
		write_priority(1'b0, 3'd4);
		write_priority(1'b1, 3'd4);
		run_lines("equal priority", 2, 1'b0, 1'b0, 1'b0);

		write_priority(1'b0, 3'd3);
		write_priority(1'b1, 3'd0);
		run_lines("zero priority", 1, 1'b1, 1'b0, 1'b0);

		run_lines("random priority", 6, 1'b0, 1'b0, 1'b1);

		$display("all tests passed");
		$finish;
	end

endmodule

//--- list.f
design/tilemap_pkg.sv
design/pixel_phase_timer.sv
design/line_controller.sv
design/layer_priority_regs.sv
design/tile_layer.sv
design/tilemap_mixer_top.sv
testbench/tb_tilemap_mixer.sv

//--- Bender.yml
package:
  name: tilemap_mixer

sources:
  # Design sources in compile order
  - files:
      - design/tilemap_pkg.sv
      - design/pixel_phase_timer.sv
      - design/line_controller.sv
      - design/layer_priority_regs.sv
      - design/tile_layer.sv
      - design/tilemap_mixer_top.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_tilemap_mixer.sv
